//--- flist.f
src/bignum_pkg.sv
src/reducer_pkg.sv
src/operand_store.sv
src/running_comparator.sv
src/block_subtractor.sv
src/reduction_ctrl.sv
src/modular_reducer_top.sv
bench/modular_reducer_sva.sv
bench/modular_reducer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module modular_reducer_tb \
    -o modular_reducer_sim &&
./obj_dir/modular_reducer_sim || exit 1

//--- bench/modular_reducer_tb.sv
`default_nettype none

module modular_reducer_tb;

    import bignum_pkg::*;
    import reducer_pkg::*;

    localparam int WIDTH   = REGISTER_SIZE * NUM_BLOCKS;
    localparam int RS      = REGISTER_SIZE;
    localparam int TIMEOUT = 100;

    typedef logic [WIDTH-1:0] wide_t;

    logic        clk_in = 1'b0;
    logic        rst_in;
    load_req_t   load;
    logic        start;
    out_block_t  result;
    logic        busy;
    logic        done;
    logic        subtracted;
    logic [31:0] lfsr_state;

    modular_reducer_top uut (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .load       (load),
        .start      (start),
        .result     (result),
        .busy       (busy),
        .done       (done),
        .subtracted (subtracted)
    );

    always #5 clk_in = ~clk_in;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic wide_t random_number();
        wide_t value;
        for (int i = 0; i < WIDTH; i++) begin
            value[i] = lfsr_bit();
        end
        return value;
    endfunction

    task automatic stop_with_failure(string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compare_block(block_t got, block_t expected, string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s: got %h, expected %h",
                                        $time, what, got, expected));
        end
    endtask

    task automatic compare_flag(logic got, logic expected, string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s: got %b, expected %b",
                                        $time, what, got, expected));
        end
    endtask

    task automatic compare_count(int got, int expected, string what);
        if (got != expected) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s: got %0d, expected %0d",
                                        $time, what, got, expected));
        end
    endtask

    task automatic load_number(operand_sel_t sel, wide_t value);
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            load = '{valid: 1'b1, sel: sel, addr: block_idx_t'(i),
                     data: value[i*RS +: RS]};
            @(posedge clk_in);
            #1;
        end
        load = '0;
    endtask

    // Loads both operands, runs one reduction and checks stream, timing and flag
    task automatic run_reduction(wide_t a, wide_t n, logic poke_busy);
        wide_t  expected;
        logic   exp_sub;
        block_t got_blocks [NUM_BLOCKS];
        int     cycles;
        int     blocks;
        int     first_cycle;
        logic   seen_done;
        exp_sub  = (a >= n);
        expected = exp_sub ? a - n : a;
        load_number(SEL_A, a);
        load_number(SEL_N, n);
        start = 1'b1;
        @(posedge clk_in);
        #1;
        start       = 1'b0;
        cycles      = 0;
        blocks      = 0;
        first_cycle = -1;
        seen_done   = 1'b0;
        while (!seen_done) begin
            @(posedge clk_in);
            #1;
            cycles++;
            // A second start sampled on the done cycle, with busy still high, must be ignored
            start = poke_busy && (cycles == 2 * NUM_BLOCKS + 2);
            if (result.valid) begin
                if (first_cycle < 0) begin
                    first_cycle = cycles;
                end
                if (blocks < NUM_BLOCKS) begin
                    got_blocks[blocks] = result.data;
                end
                compare_flag(result.last, blocks == NUM_BLOCKS - 1, "result.last");
                compare_flag(done, blocks == NUM_BLOCKS - 1, "done with result block");
                blocks++;
            end
            seen_done = done;
            if (cycles > TIMEOUT) begin
                stop_with_failure($sformatf("Timed out at time %0t waiting for done", $time));
            end
        end
        compare_count(first_cycle, NUM_BLOCKS + 4, "cycles from start to first block");
        compare_count(cycles, 2 * NUM_BLOCKS + 3, "cycles from start to done");
        compare_count(blocks, NUM_BLOCKS, "result blocks per run");
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            compare_block(got_blocks[i], expected[i*RS +: RS], $sformatf("result block %0d", i));
        end
        compare_flag(subtracted, exp_sub, "subtracted flag");
        cycles = 0;
        while (busy) begin
            @(posedge clk_in);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_failure($sformatf("Timed out at time %0t waiting for idle", $time));
            end
        end
        // Nothing may follow the run once the controller is idle
        for (int i = 0; i < 2 * NUM_BLOCKS + 4; i++) begin
            compare_flag(result.valid, 1'b0, "result.valid while idle");
            compare_flag(busy, 1'b0, "busy while idle");
            @(posedge clk_in);
            #1;
        end
    endtask

    task automatic test_less_top_block();
        wide_t a;
        wide_t n;
        a = random_number();
        n = a;
        a[WIDTH-1 -: RS] = 32'h1234_0000;
        n[WIDTH-1 -: RS] = 32'h1234_0001;
        run_reduction(a, n, 1'b0);
    endtask

    task automatic test_borrow_chain();
        wide_t a;
        wide_t n;
        a = '0;
        n = '1;
        a[WIDTH-1 -: RS] = 32'h0000_0005;
        n[WIDTH-1 -: RS] = 32'h0000_0002;
        run_reduction(a, n, 1'b0);
    endtask

    task automatic test_equal();
        wide_t a;
        a = random_number();
        run_reduction(a, a, 1'b0);
    endtask

    // Blocks 4 to 7 equal, block 3 decides, block 0 points the other way
    task automatic test_lower_block_decides();
        wide_t a;
        wide_t n;
        a = random_number();
        n = a;
        a[3*RS +: RS] = 32'h8000_0001;
        n[3*RS +: RS] = 32'h8000_0000;
        a[0 +: RS] = '0;
        n[0 +: RS] = '1;
        run_reduction(a, n, 1'b0);
        run_reduction(n, a, 1'b0);
    endtask

    // With the top bit of N set, any A stays below 2N
    task automatic test_random_runs();
        wide_t a;
        wide_t n;
        for (int k = 0; k < 6; k++) begin
            a = random_number();
            n = random_number();
            n[WIDTH-1] = 1'b1;
            run_reduction(a, n, k == 2);
        end
    endtask

    initial begin
        lfsr_state = 32'h5578;
        rst_in     = 1'b1;
        load       = '0;
        start      = 1'b0;
        repeat (10) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        test_less_top_block();
        test_borrow_chain();
        test_equal();
        test_lower_block_decides();
        test_random_runs();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/modular_reducer_sva.sv
`default_nettype none

// Protocol checks on the reducer controller
module modular_reducer_sva (
    input logic clk_in,
    input logic rst_in,
    input logic start,
    input logic busy,
    input logic done
);

    import bignum_pkg::*;

    // done lasts exactly one cycle
    assert property (@(posedge clk_in) disable iff (rst_in) done |=> !done)
        else $error("done held high for more than one cycle");

    // An accepted start raises busy
    assert property (@(posedge clk_in) disable iff (rst_in) (start && !busy) |=> busy)
        else $error("busy did not rise after start");

    // busy may only drop on the cycle after done
    assert property (@(posedge clk_in) disable iff (rst_in) $fell(busy) |-> $past(done))
        else $error("busy fell before done");

    // Both passes take a fixed time, so done trails the accepted start by a fixed count
    assert property (@(posedge clk_in) disable iff (rst_in)
                     done |-> $past(start && !busy, 2 * NUM_BLOCKS + 4))
        else $error("done not aligned with the accepted start");

endmodule

bind reduction_ctrl modular_reducer_sva ctrl_checks (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .start  (start),
    .busy   (busy),
    .done   (done)
);

`default_nettype wire

//--- src/modular_reducer_top.sv
`default_nettype none

// Conditional-subtract reducer: emits A - N when A >= N, else A
module modular_reducer_top (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  reducer_pkg::load_req_t  load,
    input  logic                    start,
    output reducer_pkg::out_block_t result,
    output logic                    busy,
    output logic                    done,
    output logic                    subtracted
);

    import bignum_pkg::*;

    block_idx_t  rd_addr;
    block_t      a_block;
    block_t      n_block;
    cmp_result_t cmp_result;

    logic cmp_valid;
    logic sub_valid;
    logic sub_first;
    logic sub_last;
    logic sub_en;

    operand_store store (
        .clk_in  (clk_in),
        .load    (load),
        .rd_addr (rd_addr),
        .a_block (a_block),
        .n_block (n_block)
    );

    running_comparator comparator (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .valid   (cmp_valid),
        .block_a (a_block),
        .block_b (n_block),
        .result  (cmp_result)
    );

    block_subtractor subtractor (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .valid   (sub_valid),
        .first   (sub_first),
        .last    (sub_last),
        .sub_en  (sub_en),
        .block_a (a_block),
        .block_n (n_block),
        .result  (result)
    );

    reduction_ctrl ctrl (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start      (start),
        .cmp_result (cmp_result),
        .rd_addr    (rd_addr),
        .cmp_valid  (cmp_valid),
        .sub_valid  (sub_valid),
        .sub_first  (sub_first),
        .sub_last   (sub_last),
        .sub_en     (sub_en),
        .busy       (busy),
        .done       (done),
        .subtracted (subtracted)
    );

endmodule

`default_nettype wire

//--- src/reduction_ctrl.sv
`default_nettype none

// Sequences compare pass, decision and output pass of the reducer
module reduction_ctrl (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    start,
    input  bignum_pkg::cmp_result_t cmp_result,
    output bignum_pkg::block_idx_t  rd_addr,
    output logic                    cmp_valid,
    output logic                    sub_valid,
    output logic                    sub_first,
    output logic                    sub_last,
    output logic                    sub_en,
    output logic                    busy,
    output logic                    done,
    output logic                    subtracted
);

    import bignum_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_DECIDE,
        ST_EMIT
    } state_t;

    state_t     state;
    block_idx_t cnt;

    logic issue_cmp;
    logic issue_sub;
    logic cmp_valid_q;
    logic sub_valid_q;
    logic sub_first_q;
    logic sub_last_q;
    logic busy_q;
    logic done_q;
    logic take_sub;

    assign rd_addr = cnt;

    // Compare pass counts one past the last block to let the result settle
    assign issue_cmp = (state == ST_COMPARE) && (cnt != BLOCK_COUNT);
    assign issue_sub = (state == ST_EMIT);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            cmp_valid_q <= 1'b0;
            sub_valid_q <= 1'b0;
            sub_first_q <= 1'b0;
            sub_last_q  <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            take_sub    <= 1'b0;
        end else begin
            // Strobes trail the address by the store read latency
            cmp_valid_q <= issue_cmp;
            sub_valid_q <= issue_sub;
            sub_first_q <= issue_sub && (cnt == '0);
            sub_last_q  <= issue_sub && (cnt == LAST_IDX);
            // Last result block leaves the subtractor one cycle later
            done_q      <= sub_last_q;

            if (done_q) begin
                busy_q <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (start && !busy_q) begin
                        state    <= ST_COMPARE;
                        cnt      <= '0;
                        busy_q   <= 1'b1;
                        take_sub <= 1'b0;
                    end
                end
                ST_COMPARE: begin
                    if (cnt == BLOCK_COUNT) begin
                        state <= ST_DECIDE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_DECIDE: begin
                    take_sub <= (cmp_result == CMP_A_EQUAL) || (cmp_result == CMP_A_GREATER);
                    state    <= ST_EMIT;
                    cnt      <= '0;
                end
                ST_EMIT: begin
                    if (cnt == LAST_IDX) begin
                        state <= ST_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign cmp_valid  = cmp_valid_q;
    assign sub_valid  = sub_valid_q;
    assign sub_first  = sub_first_q;
    assign sub_last   = sub_last_q;
    assign sub_en     = take_sub;
    assign subtracted = take_sub;
    assign busy       = busy_q;
    assign done       = done_q;

endmodule

`default_nettype wire

//--- src/block_subtractor.sv
`default_nettype none

// Block-serial A - N with a borrow chain, or A passed through unchanged
module block_subtractor (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    valid,
    input  logic                    first,
    input  logic                    last,
    input  logic                    sub_en,
    input  bignum_pkg::block_t      block_a,
    input  bignum_pkg::block_t      block_n,
    output reducer_pkg::out_block_t result
);

    import bignum_pkg::*;

    logic [REGISTER_SIZE:0] diff;
    logic                   borrow_in;
    logic                   borrow_q;
    logic                   valid_q;
    logic                   last_q;
    block_t                 data_q;

    // No borrow into the least significant block
    assign borrow_in = first ? 1'b0 : borrow_q;

    // MSB of the widened difference is the borrow out
    assign diff = {1'b0, block_a} - {1'b0, block_n} - {{REGISTER_SIZE{1'b0}}, borrow_in};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            borrow_q <= 1'b0;
        end else begin
            valid_q <= valid;
            last_q  <= valid && last;
            if (valid && sub_en) begin
                borrow_q <= diff[REGISTER_SIZE];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (valid) begin
            data_q <= sub_en ? diff[REGISTER_SIZE-1:0] : block_a;
        end
    end

    assign result = '{valid: valid_q, last: last_q, data: data_q};

endmodule

`default_nettype wire

//--- src/running_comparator.sv
`default_nettype none

// Magnitude compare of two numbers streamed least significant block first.
// The result is ready one cycle after the last block
module running_comparator (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    valid,
    input  bignum_pkg::block_t      block_a,
    input  bignum_pkg::block_t      block_b,
    output bignum_pkg::cmp_result_t result
);

    import bignum_pkg::*;

    cmp_result_t state;
    block_idx_t  block_count;

    // Verdict from a single pair of blocks
    function automatic cmp_result_t classify(block_t a, block_t b);
        cmp_result_t res;
        if (a == b) begin
            res = CMP_A_EQUAL;
        end else if (a < b) begin
            res = CMP_A_LESS;
        end else begin
            res = CMP_A_GREATER;
        end
        return res;
    endfunction

    assign result = state;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= CMP_NULL;
            block_count <= '0;
        end else if (block_count == BLOCK_COUNT) begin
            // Previous number complete; start over or fall back to null
            if (valid) begin
                block_count <= block_idx_t'(1);
                state       <= classify(block_a, block_b);
            end else begin
                block_count <= '0;
                state       <= CMP_NULL;
            end
        end else if (valid) begin
            block_count <= block_count + 1'b1;
            case (state)
                CMP_NULL, CMP_A_EQUAL: begin
                    state <= classify(block_a, block_b);
                end
                CMP_A_LESS: begin
                    // Higher block wins, equal blocks keep the old verdict
                    if (block_a > block_b) begin
                        state <= CMP_A_GREATER;
                    end
                end
                CMP_A_GREATER: begin
                    if (block_a < block_b) begin
                        state <= CMP_A_LESS;
                    end
                end
                default: begin
                    state <= CMP_NULL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/operand_store.sv
`default_nettype none

// Block storage for operand A and modulus N
module operand_store (
    input  logic                   clk_in,
    input  reducer_pkg::load_req_t load,
    input  bignum_pkg::block_idx_t rd_addr,
    output bignum_pkg::block_t     a_block,
    output bignum_pkg::block_t     n_block
);

    import bignum_pkg::*;
    import reducer_pkg::*;

    block_t mem_a [NUM_BLOCKS];
    block_t mem_n [NUM_BLOCKS];

    logic [ADDR_W-1:0] wr_idx;
    logic [ADDR_W-1:0] rd_idx;

    // Top address bit only matters for counters, not for storage
    assign wr_idx = load.addr[ADDR_W-1:0];
    assign rd_idx = rd_addr[ADDR_W-1:0];

    always_ff @(posedge clk_in) begin
        if (load.valid) begin
            if (load.sel == SEL_A) begin
                mem_a[wr_idx] <= load.data;
            end else begin
                mem_n[wr_idx] <= load.data;
            end
        end
    end

    // Both operands come out together, one cycle after the address
    always_ff @(posedge clk_in) begin
        a_block <= mem_a[rd_idx];
        n_block <= mem_n[rd_idx];
    end

endmodule

`default_nettype wire

//--- src/reducer_pkg.sv
package reducer_pkg;

    // Which operand memory a load writes into
    typedef enum logic {
        SEL_A,
        SEL_N
    } operand_sel_t;

    // One block written into the operand store
    typedef struct packed {
        logic                   valid;
        operand_sel_t           sel;
        bignum_pkg::block_idx_t addr;
        bignum_pkg::block_t     data;
    } load_req_t;

    // One block of the result stream
    typedef struct packed {
        logic               valid;
        logic               last;
        bignum_pkg::block_t data;
    } out_block_t;

endpackage

//--- src/bignum_pkg.sv
package bignum_pkg;

    // Number format: NUM_BLOCKS blocks, least significant block first
    localparam int REGISTER_SIZE = 32;
    localparam int NUM_BLOCKS    = 8;

    // Bits needed to address one block of a number
    localparam int ADDR_W = $clog2(NUM_BLOCKS);

    typedef logic [REGISTER_SIZE-1:0] block_t;

    // One extra bit so a counter can reach NUM_BLOCKS itself
    typedef logic [ADDR_W:0] block_idx_t;

    localparam block_idx_t BLOCK_COUNT = block_idx_t'(NUM_BLOCKS);
    localparam block_idx_t LAST_IDX    = block_idx_t'(NUM_BLOCKS - 1);

    // Running comparison state, null until the first block is seen
    typedef enum logic [1:0] {
        CMP_NULL,
        CMP_A_LESS,
        CMP_A_EQUAL,
        CMP_A_GREATER
    } cmp_result_t;

endpackage
